//--- hdl/cache_memctrl_pkg.sv
/*
 * Cache geometry constants, index and data word types,
 * directory entry struct and the line number union
 */
`default_nettype none

package cache_memctrl_pkg;

    localparam int unsigned SETS           = 16;
    localparam int unsigned WAYS           = 4;
    localparam int unsigned LINE_WORDS     = 4;
    localparam int unsigned WORD_WIDTH     = 32;
    localparam int unsigned TAG_WIDTH      = 8;
    localparam int unsigned BYTES_PER_WORD = WORD_WIDTH / 8;

    localparam int unsigned SET_WIDTH      = $clog2(SETS);
    localparam int unsigned WORD_IDX_WIDTH = $clog2(LINE_WORDS);
    localparam int unsigned DATA_ADDR_WIDTH = SET_WIDTH + WORD_IDX_WIDTH;

    typedef logic [SET_WIDTH-1:0]       set_t;
    typedef logic [TAG_WIDTH-1:0]       tag_t;
    typedef logic [WORD_IDX_WIDTH-1:0]  word_idx_t;
    typedef logic [WAYS-1:0]            way_vec_t;
    typedef logic [WORD_WIDTH-1:0]      data_word_t;
    typedef logic [BYTES_PER_WORD-1:0]  be_t;

    // Data RAM row, set in the upper bits and word in the lower
    typedef logic [DATA_ADDR_WIDTH-1:0] data_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } dir_entry_t;

    // Line number seen either whole or split into tag and set
    typedef union packed {
        logic [TAG_WIDTH+SET_WIDTH-1:0] raw;
        struct packed {
            tag_t tag;
            set_t set;
        } fields;
    } line_addr_u;

endpackage

`default_nettype wire

//--- hdl/sram_1rw.sv
/*
 * Generic single-port RAM, byte-enabled synchronous write
 * and registered read on chip-select
 */
`default_nettype none

module sram_1rw #(
    parameter int unsigned Depth = 16,
    parameter int unsigned Width = 32,
    localparam int unsigned AddrWidth = $clog2(Depth),
    localparam int unsigned BeWidth = (Width + 7) / 8
) (
    input  wire logic                 clk_i,
    input  wire logic                 cs_i,
    input  wire logic                 we_i,
    input  wire logic [AddrWidth-1:0] addr_i,
    input  wire logic [Width-1:0]     wdata_i,
    input  wire logic [BeWidth-1:0]   be_i,
    output logic      [Width-1:0]     rdata_o
);

    logic [Width-1:0] mem_q [Depth];

    always_ff @(posedge clk_i) begin
        if (cs_i && we_i) begin
            // A partial last byte follows the enable of its byte lane
            for (int i = 0; i < Width; i++) begin
                if (be_i[i/8]) begin
                    mem_q[addr_i][i] <= wdata_i[i];
                end
            end
        end else if (cs_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

`default_nettype wire

//--- hdl/dir_access_arb.sv
/*
 * Init sequencer and ready flag, directory and data access
 * muxes, access exclusion checks
 */
`default_nettype none

module dir_access_arb (
    input  wire logic                            clk_i,
    input  wire logic                            rst_ni,
    input  wire logic                            lookup_i,
    input  wire cache_memctrl_pkg::line_addr_u   lookup_line_i,
    input  wire logic                            dir_refill_i,
    input  wire cache_memctrl_pkg::set_t         refill_set_i,
    input  wire cache_memctrl_pkg::way_vec_t     refill_way_i,
    input  wire cache_memctrl_pkg::tag_t         refill_tag_i,
    input  wire logic                            refill_dirty_i,
    input  wire logic                            data_read_i,
    input  wire cache_memctrl_pkg::set_t         read_set_i,
    input  wire cache_memctrl_pkg::word_idx_t    read_word_i,
    input  wire logic                            data_write_i,
    input  wire cache_memctrl_pkg::set_t         write_set_i,
    input  wire cache_memctrl_pkg::way_vec_t     write_way_i,
    input  wire cache_memctrl_pkg::word_idx_t    write_word_i,
    input  wire cache_memctrl_pkg::data_word_t   write_data_i,
    input  wire cache_memctrl_pkg::be_t          write_be_i,
    output logic                                 ready_o,
    output cache_memctrl_pkg::set_t              dir_addr_o,
    output cache_memctrl_pkg::way_vec_t          dir_cs_o,
    output cache_memctrl_pkg::way_vec_t          dir_we_o,
    output cache_memctrl_pkg::dir_entry_t        dir_wentry_o,
    output cache_memctrl_pkg::data_addr_t        data_addr_o,
    output cache_memctrl_pkg::way_vec_t          data_cs_o,
    output cache_memctrl_pkg::way_vec_t          data_we_o,
    output cache_memctrl_pkg::data_word_t        data_wdata_o,
    output cache_memctrl_pkg::be_t               data_be_o
);

    cache_memctrl_pkg::set_t init_set_q;
    logic                    init_done_q;

    // Walk every set once, one per cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_set_q  <= '0;
            init_done_q <= 1'b0;
        end else if (!init_done_q) begin
            init_set_q  <= init_set_q + 1'b1;
            init_done_q <= (init_set_q == cache_memctrl_pkg::set_t'(cache_memctrl_pkg::SETS - 1));
        end
    end

    assign ready_o = init_done_q;

    // Directory port, init first, then lookup, then refill
    always_comb begin
        dir_addr_o   = '0;
        dir_cs_o     = '0;
        dir_we_o     = '0;
        dir_wentry_o = '0;
        if (!init_done_q) begin
            dir_addr_o = init_set_q;
            dir_cs_o   = '1;
            dir_we_o   = '1;
        end else if (lookup_i) begin
            dir_addr_o = lookup_line_i.fields.set;
            dir_cs_o   = '1;
        end else if (dir_refill_i) begin
            dir_addr_o         = refill_set_i;
            dir_cs_o           = refill_way_i;
            dir_we_o           = refill_way_i;
            dir_wentry_o.valid = 1'b1;
            dir_wentry_o.dirty = refill_dirty_i;
            dir_wentry_o.tag   = refill_tag_i;
        end
    end

    // Data port; reads open every way, writes only their own
    always_comb begin
        data_addr_o  = '0;
        data_cs_o    = '0;
        data_we_o    = '0;
        data_wdata_o = write_data_i;
        data_be_o    = write_be_i;
        if (init_done_q && data_read_i) begin
            data_addr_o = {read_set_i, read_word_i};
            data_cs_o   = '1;
        end else if (init_done_q && data_write_i) begin
            data_addr_o = {write_set_i, write_word_i};
            data_cs_o   = write_way_i;
            data_we_o   = write_way_i;
        end
    end

    dir_strobe_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({lookup_i, dir_refill_i}))
        else $error("lookup and refill strobed together");

    data_strobe_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({data_read_i, data_write_i}))
        else $error("data read and write strobed together");

    refill_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dir_refill_i |-> $onehot(refill_way_i))
        else $error("refill way is not one-hot");

endmodule

`default_nettype wire

//--- hdl/dir_array.sv
/*
 * Per-way directory RAMs, registered lookup tag and
 * the per-way hit compare
 */
`default_nettype none

module dir_array (
    input  wire logic                          clk_i,
    input  wire logic                          rst_ni,
    input  wire cache_memctrl_pkg::set_t       addr_i,
    input  wire cache_memctrl_pkg::way_vec_t   cs_i,
    input  wire cache_memctrl_pkg::way_vec_t   we_i,
    input  wire cache_memctrl_pkg::dir_entry_t wentry_i,
    input  wire logic                          lookup_i,
    input  wire cache_memctrl_pkg::tag_t       lookup_tag_i,
    output cache_memctrl_pkg::way_vec_t        hit_way_o,
    output cache_memctrl_pkg::dir_entry_t [cache_memctrl_pkg::WAYS-1:0] entries_o
);

    localparam int unsigned EntryWidth = $bits(cache_memctrl_pkg::dir_entry_t);

    cache_memctrl_pkg::tag_t lookup_tag_q;

    // Tag waits one cycle for the RAM rows
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_tag_q <= '0;
        end else if (lookup_i) begin
            lookup_tag_q <= lookup_tag_i;
        end
    end

    for (genvar w = 0; w < cache_memctrl_pkg::WAYS; w++) begin : g_way
        sram_1rw #(
            .Depth   (cache_memctrl_pkg::SETS),
            .Width   (EntryWidth)
        ) u_dir_ram (
            .clk_i   (clk_i),
            .cs_i    (cs_i[w]),
            .we_i    (we_i[w]),
            .addr_i  (addr_i),
            .wdata_i (wentry_i),
            .be_i    ('1),
            .rdata_o (entries_o[w])
        );

        assign hit_way_o[w] = entries_o[w].valid && (entries_o[w].tag == lookup_tag_q);
    end

endmodule

`default_nettype wire

//--- hdl/data_array.sv
/*
 * Per-way data RAMs, one word per row,
 * rows addressed by set and line word
 */
`default_nettype none

module data_array (
    input  wire logic                          clk_i,
    input  wire cache_memctrl_pkg::data_addr_t addr_i,
    input  wire cache_memctrl_pkg::way_vec_t   cs_i,
    input  wire cache_memctrl_pkg::way_vec_t   we_i,
    input  wire cache_memctrl_pkg::data_word_t wdata_i,
    input  wire cache_memctrl_pkg::be_t        be_i,
    output cache_memctrl_pkg::data_word_t [cache_memctrl_pkg::WAYS-1:0] rdata_o
);

    localparam int unsigned RamDepth = cache_memctrl_pkg::SETS * cache_memctrl_pkg::LINE_WORDS;

    // Write word and enables go to every way, we_i picks the one that takes it
    for (genvar w = 0; w < cache_memctrl_pkg::WAYS; w++) begin : g_way
        sram_1rw #(
            .Depth   (RamDepth),
            .Width   (cache_memctrl_pkg::WORD_WIDTH)
        ) u_data_ram (
            .clk_i   (clk_i),
            .cs_i    (cs_i[w]),
            .we_i    (we_i[w]),
            .addr_i  (addr_i),
            .wdata_i (wdata_i),
            .be_i    (be_i),
            .rdata_o (rdata_o[w])
        );
    end

endmodule

`default_nettype wire

//--- hdl/read_resp.sv
/*
 * Response side, one-hot selection of hit tag,
 * dirty flag and read word by the hit way
 */
`default_nettype none

module read_resp (
    input  wire cache_memctrl_pkg::way_vec_t hit_way_i,
    input  wire cache_memctrl_pkg::dir_entry_t [cache_memctrl_pkg::WAYS-1:0] entries_i,
    input  wire cache_memctrl_pkg::data_word_t [cache_memctrl_pkg::WAYS-1:0] rdata_i,
    output cache_memctrl_pkg::way_vec_t      hit_way_o,
    output cache_memctrl_pkg::tag_t          hit_tag_o,
    output logic                             hit_dirty_o,
    output cache_memctrl_pkg::data_word_t    read_data_o
);

    assign hit_way_o = hit_way_i;

    // AND-OR mux, a miss gives all zeros
    always_comb begin
        hit_tag_o   = '0;
        hit_dirty_o = 1'b0;
        read_data_o = '0;
        for (int w = 0; w < cache_memctrl_pkg::WAYS; w++) begin
            hit_tag_o   |= entries_i[w].tag & {cache_memctrl_pkg::TAG_WIDTH{hit_way_i[w]}};
            hit_dirty_o |= entries_i[w].dirty & hit_way_i[w];
            read_data_o |= rdata_i[w] & {cache_memctrl_pkg::WORD_WIDTH{hit_way_i[w]}};
        end
    end

    // Two valid ways holding one tag would mean a bad refill upstream
    always_comb begin
        hit_way_onehot: assert final ($isunknown(hit_way_i) || $onehot0(hit_way_i))
            else $error("hit way is not one-hot");
    end

endmodule

`default_nettype wire

//--- hdl/cache_memctrl_top.sv
/*
 * Cache directory and data memory controller top,
 * access arbiter, directory, data RAMs and response mux
 */
`default_nettype none

module cache_memctrl_top (
    input  wire logic                          clk_i,
    input  wire logic                          rst_ni,
    output logic                               ready_o,
    input  wire logic                          lookup_i,
    input  wire cache_memctrl_pkg::line_addr_u lookup_line_i,
    input  wire logic                          dir_refill_i,
    input  wire cache_memctrl_pkg::set_t       refill_set_i,
    input  wire cache_memctrl_pkg::way_vec_t   refill_way_i,
    input  wire cache_memctrl_pkg::tag_t       refill_tag_i,
    input  wire logic                          refill_dirty_i,
    input  wire logic                          data_read_i,
    input  wire cache_memctrl_pkg::set_t       read_set_i,
    input  wire cache_memctrl_pkg::word_idx_t  read_word_i,
    input  wire logic                          data_write_i,
    input  wire cache_memctrl_pkg::set_t       write_set_i,
    input  wire cache_memctrl_pkg::way_vec_t   write_way_i,
    input  wire cache_memctrl_pkg::word_idx_t  write_word_i,
    input  wire cache_memctrl_pkg::data_word_t write_data_i,
    input  wire cache_memctrl_pkg::be_t        write_be_i,
    output cache_memctrl_pkg::way_vec_t        hit_way_o,
    output cache_memctrl_pkg::tag_t            hit_tag_o,
    output logic                               hit_dirty_o,
    output cache_memctrl_pkg::data_word_t      read_data_o
);

    cache_memctrl_pkg::set_t       dir_addr;
    cache_memctrl_pkg::way_vec_t   dir_cs;
    cache_memctrl_pkg::way_vec_t   dir_we;
    cache_memctrl_pkg::dir_entry_t dir_wentry;
    cache_memctrl_pkg::data_addr_t data_addr;
    cache_memctrl_pkg::way_vec_t   data_cs;
    cache_memctrl_pkg::way_vec_t   data_we;
    cache_memctrl_pkg::data_word_t data_wdata;
    cache_memctrl_pkg::be_t        data_be;
    cache_memctrl_pkg::way_vec_t   dir_hit_way;

    cache_memctrl_pkg::dir_entry_t [cache_memctrl_pkg::WAYS-1:0] dir_entries;
    cache_memctrl_pkg::data_word_t [cache_memctrl_pkg::WAYS-1:0] data_rwords;

    dir_access_arb u_arb (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .lookup_i       (lookup_i),
        .lookup_line_i  (lookup_line_i),
        .dir_refill_i   (dir_refill_i),
        .refill_set_i   (refill_set_i),
        .refill_way_i   (refill_way_i),
        .refill_tag_i   (refill_tag_i),
        .refill_dirty_i (refill_dirty_i),
        .data_read_i    (data_read_i),
        .read_set_i     (read_set_i),
        .read_word_i    (read_word_i),
        .data_write_i   (data_write_i),
        .write_set_i    (write_set_i),
        .write_way_i    (write_way_i),
        .write_word_i   (write_word_i),
        .write_data_i   (write_data_i),
        .write_be_i     (write_be_i),
        .ready_o        (ready_o),
        .dir_addr_o     (dir_addr),
        .dir_cs_o       (dir_cs),
        .dir_we_o       (dir_we),
        .dir_wentry_o   (dir_wentry),
        .data_addr_o    (data_addr),
        .data_cs_o      (data_cs),
        .data_we_o      (data_we),
        .data_wdata_o   (data_wdata),
        .data_be_o      (data_be)
    );

    dir_array u_dir (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .addr_i         (dir_addr),
        .cs_i           (dir_cs),
        .we_i           (dir_we),
        .wentry_i       (dir_wentry),
        .lookup_i       (lookup_i),
        .lookup_tag_i   (lookup_line_i.fields.tag),
        .hit_way_o      (dir_hit_way),
        .entries_o      (dir_entries)
    );

    data_array u_data (
        .clk_i          (clk_i),
        .addr_i         (data_addr),
        .cs_i           (data_cs),
        .we_i           (data_we),
        .wdata_i        (data_wdata),
        .be_i           (data_be),
        .rdata_o        (data_rwords)
    );

    read_resp u_resp (
        .hit_way_i      (dir_hit_way),
        .entries_i      (dir_entries),
        .rdata_i        (data_rwords),
        .hit_way_o      (hit_way_o),
        .hit_tag_o      (hit_tag_o),
        .hit_dirty_o    (hit_dirty_o),
        .read_data_o    (read_data_o)
    );

endmodule

`default_nettype wire

//--- bench/cache_memctrl_checks.svh
/*
 * LFSR random source and typed compare tasks
 * for the cache controller testbench
 */
`ifndef CACHE_MEMCTRL_CHECKS_SVH
`define CACHE_MEMCTRL_CHECKS_SVH

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h800e;

function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// One LFSR step for every bit handed out
function automatic logic [31:0] rand_bits(input int unsigned count);
    logic [31:0] value;
    value = '0;
    for (int unsigned i = 0; i < count; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        value = {value[30:0], lfsr_state[0]};
    end
    return value;
endfunction

task automatic check_way(input string name, input cache_memctrl_pkg::way_vec_t actual,
                         input cache_memctrl_pkg::way_vec_t expected);
    if (actual !== expected) begin
        $display("Fail at %0t: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
        abort_run();
    end
endtask

task automatic check_tag(input string name, input cache_memctrl_pkg::tag_t actual,
                         input cache_memctrl_pkg::tag_t expected);
    if (actual !== expected) begin
        $display("Fail at %0t: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        $display("Fail at %0t: %s = %b, expected %b", $time, name, actual, expected);
        abort_run();
    end
endtask

task automatic check_word(input string name, input cache_memctrl_pkg::data_word_t actual,
                          input cache_memctrl_pkg::data_word_t expected);
    if (actual !== expected) begin
        $display("Fail at %0t: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
        abort_run();
    end
endtask

`endif

//--- bench/cache_memctrl_tb.sv
/*
 * Testbench for the cache directory and data controller,
 * access table with reference model, clock, reset, watchdog
 */
`default_nettype none

module cache_memctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned CLK_PERIOD    = 100;
    localparam int unsigned RESET_CYCLES  = 3;
    localparam int unsigned MARGIN_CYCLES = 20;

    typedef enum logic [1:0] {ACC_LOOKUP, ACC_REFILL, ACC_WRITE} acc_kind_e;

    // One table row; expected fields only matter for lookups
    typedef struct {
        acc_kind_e                     kind;
        cache_memctrl_pkg::line_addr_u line;
        int unsigned                   way;
        cache_memctrl_pkg::word_idx_t  word;
        cache_memctrl_pkg::data_word_t data;
        cache_memctrl_pkg::be_t        be;
        logic                          dirty;
        cache_memctrl_pkg::way_vec_t   exp_way;
        cache_memctrl_pkg::tag_t       exp_tag;
        logic                          exp_dirty;
        cache_memctrl_pkg::data_word_t exp_data;
    } access_t;

    logic clk = 1'b0;
    logic rst_n;
    logic ready;
    logic lookup;
    logic dir_refill;
    logic refill_dirty;
    logic data_read;
    logic data_write;
    logic hit_dirty;

    cache_memctrl_pkg::line_addr_u lookup_line;
    cache_memctrl_pkg::set_t       refill_set;
    cache_memctrl_pkg::way_vec_t   refill_way;
    cache_memctrl_pkg::tag_t       refill_tag;
    cache_memctrl_pkg::set_t       read_set;
    cache_memctrl_pkg::word_idx_t  read_word;
    cache_memctrl_pkg::set_t       write_set;
    cache_memctrl_pkg::way_vec_t   write_way;
    cache_memctrl_pkg::word_idx_t  write_word;
    cache_memctrl_pkg::data_word_t write_data;
    cache_memctrl_pkg::be_t        write_be;
    cache_memctrl_pkg::way_vec_t   hit_way;
    cache_memctrl_pkg::tag_t       hit_tag;
    cache_memctrl_pkg::data_word_t read_data;

    access_t steps[$];

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    `include "cache_memctrl_checks.svh"

    cache_memctrl_top DUT (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .ready_o        (ready),
        .lookup_i       (lookup),
        .lookup_line_i  (lookup_line),
        .dir_refill_i   (dir_refill),
        .refill_set_i   (refill_set),
        .refill_way_i   (refill_way),
        .refill_tag_i   (refill_tag),
        .refill_dirty_i (refill_dirty),
        .data_read_i    (data_read),
        .read_set_i     (read_set),
        .read_word_i    (read_word),
        .data_write_i   (data_write),
        .write_set_i    (write_set),
        .write_way_i    (write_way),
        .write_word_i   (write_word),
        .write_data_i   (write_data),
        .write_be_i     (write_be),
        .hit_way_o      (hit_way),
        .hit_tag_o      (hit_tag),
        .hit_dirty_o    (hit_dirty),
        .read_data_o    (read_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic access_t blank_access(input acc_kind_e kind,
                                             input cache_memctrl_pkg::tag_t tag,
                                             input cache_memctrl_pkg::set_t set);
        access_t a;
        a.kind             = kind;
        a.line.fields.tag  = tag;
        a.line.fields.set  = set;
        a.way              = 0;
        a.word             = '0;
        a.data             = '0;
        a.be               = '0;
        a.dirty            = 1'b0;
        a.exp_way          = '0;
        a.exp_tag          = '0;
        a.exp_dirty        = 1'b0;
        a.exp_data         = '0;
        return a;
    endfunction

    // Lookups always carry a data read of the same set
    task automatic add_lookup(input cache_memctrl_pkg::tag_t tag,
                              input cache_memctrl_pkg::set_t set,
                              input cache_memctrl_pkg::word_idx_t word);
        access_t a;
        a = blank_access(ACC_LOOKUP, tag, set);
        a.word = word;
        steps.push_back(a);
    endtask

    task automatic add_refill(input cache_memctrl_pkg::tag_t tag,
                              input cache_memctrl_pkg::set_t set,
                              input int unsigned way, input logic dirty);
        access_t a;
        a = blank_access(ACC_REFILL, tag, set);
        a.way   = way;
        a.dirty = dirty;
        steps.push_back(a);
    endtask

    task automatic add_write(input cache_memctrl_pkg::set_t set, input int unsigned way,
                             input cache_memctrl_pkg::word_idx_t word,
                             input cache_memctrl_pkg::be_t be);
        access_t a;
        a = blank_access(ACC_WRITE, '0, set);
        a.way  = way;
        a.word = word;
        a.be   = be;
        a.data = rand_bits(32);
        steps.push_back(a);
    endtask

    task automatic build_table();
        cache_memctrl_pkg::tag_t tag;
        cache_memctrl_pkg::be_t  be;
        // Fresh directory misses everywhere
        add_lookup(8'h12, 4'd0, 2'd0);
        add_lookup(8'h5a, 4'd3, 2'd1);
        add_lookup(8'hc4, 4'd15, 2'd3);
        // Single refill with its line filled, then hit on its tag and miss on a neighbour
        add_refill(8'h5a, 4'd3, 1, 1'b0);
        for (int unsigned w = 0; w < cache_memctrl_pkg::LINE_WORDS; w++) begin
            add_write(4'd3, 1, cache_memctrl_pkg::word_idx_t'(w), '1);
        end
        add_lookup(8'h5a, 4'd3, 2'd0);
        add_lookup(8'h5b, 4'd3, 2'd0);
        for (int unsigned w = 0; w < cache_memctrl_pkg::LINE_WORDS; w++) begin
            add_lookup(8'h5a, 4'd3, cache_memctrl_pkg::word_idx_t'(w));
        end
        // Partial write merges into word 2
        be = '0;
        while (be == '0 || be == '1) begin
            be = cache_memctrl_pkg::be_t'(rand_bits(4));
        end
        add_write(4'd3, 1, 2'd2, be);
        add_lookup(8'h5a, 4'd3, 2'd2);
        // Second way in the same set
        add_refill(8'h77, 4'd3, 2, 1'b1);
        add_write(4'd3, 2, 2'd2, '1);
        add_lookup(8'h77, 4'd3, 2'd2);
        add_lookup(8'h5a, 4'd3, 2'd2);
        // Overwrite way 1, the old tag is gone
        add_refill(8'h3c, 4'd3, 1, 1'b1);
        add_lookup(8'h5a, 4'd3, 2'd2);
        add_lookup(8'h3c, 4'd3, 2'd2);
        for (int s = 8; s < 12; s++) begin
            tag = cache_memctrl_pkg::tag_t'(rand_bits(8));
            add_refill(tag, cache_memctrl_pkg::set_t'(s), s % 4, logic'(s % 2));
            add_write(cache_memctrl_pkg::set_t'(s), s % 4, cache_memctrl_pkg::word_idx_t'(s), '1);
            add_lookup(tag, cache_memctrl_pkg::set_t'(s), cache_memctrl_pkg::word_idx_t'(s));
        end
    endtask

    // Reference model walks the table and fills in lookup results
    task automatic fill_expected();
        logic                          valid [cache_memctrl_pkg::SETS][cache_memctrl_pkg::WAYS];
        logic                          dirty [cache_memctrl_pkg::SETS][cache_memctrl_pkg::WAYS];
        cache_memctrl_pkg::tag_t       tags  [cache_memctrl_pkg::SETS][cache_memctrl_pkg::WAYS];
        cache_memctrl_pkg::data_word_t words [cache_memctrl_pkg::WAYS][cache_memctrl_pkg::SETS]
                                             [cache_memctrl_pkg::LINE_WORDS];
        access_t                       a;
        cache_memctrl_pkg::set_t       s;
        foreach (valid[i, j]) begin
            valid[i][j] = 1'b0;
            dirty[i][j] = 1'b0;
            tags[i][j]  = '0;
        end
        foreach (steps[i]) begin
            a = steps[i];
            s = a.line.fields.set;
            case (a.kind)
                ACC_REFILL: begin
                    valid[s][a.way] = 1'b1;
                    dirty[s][a.way] = a.dirty;
                    tags[s][a.way]  = a.line.fields.tag;
                end
                ACC_WRITE: begin
                    for (int b = 0; b < cache_memctrl_pkg::BYTES_PER_WORD; b++) begin
                        if (a.be[b]) begin
                            words[a.way][s][a.word][8*b +: 8] = a.data[8*b +: 8];
                        end
                    end
                end
                default: begin
                    for (int w = 0; w < cache_memctrl_pkg::WAYS; w++) begin
                        if (valid[s][w] && tags[s][w] == a.line.fields.tag) begin
                            a.exp_way[w] = 1'b1;
                            a.exp_tag    = tags[s][w];
                            a.exp_dirty  = dirty[s][w];
                            a.exp_data   = words[w][s][a.word];
                        end
                    end
                end
            endcase
            steps[i] = a;
        end
    endtask

    task automatic drive_idle();
        lookup       = 1'b0;
        lookup_line  = '0;
        dir_refill   = 1'b0;
        refill_set   = '0;
        refill_way   = '0;
        refill_tag   = '0;
        refill_dirty = 1'b0;
        data_read    = 1'b0;
        read_set     = '0;
        read_word    = '0;
        data_write   = 1'b0;
        write_set    = '0;
        write_way    = '0;
        write_word   = '0;
        write_data   = '0;
        write_be     = '0;
    endtask

    task automatic drive_access(input access_t a);
        drive_idle();
        case (a.kind)
            ACC_LOOKUP: begin
                lookup      = 1'b1;
                lookup_line = a.line;
                data_read   = 1'b1;
                read_set    = a.line.fields.set;
                read_word   = a.word;
            end
            ACC_REFILL: begin
                dir_refill   = 1'b1;
                refill_set   = a.line.fields.set;
                refill_way   = cache_memctrl_pkg::way_vec_t'(1 << a.way);
                refill_tag   = a.line.fields.tag;
                refill_dirty = a.dirty;
            end
            default: begin
                data_write = 1'b1;
                write_set  = a.line.fields.set;
                write_way  = cache_memctrl_pkg::way_vec_t'(1 << a.way);
                write_word = a.word;
                write_data = a.data;
                write_be   = a.be;
            end
        endcase
    endtask

    initial begin : stimulus
        int unsigned low_cycles;
        rst_n = 1'b0;
        drive_idle();
        build_table();
        fill_expected();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        // Init clears one set per cycle
        low_cycles = 0;
        while (!ready) begin
            @(negedge clk);
            low_cycles++;
        end
        if (low_cycles != cache_memctrl_pkg::SETS) begin
            $display("ready_o was low for %0d cycles after reset, expected %0d",
                     low_cycles, cache_memctrl_pkg::SETS);
            abort_run();
        end
        foreach (steps[i]) begin
            drive_access(steps[i]);
            @(negedge clk);
            check_bit("ready_o", ready, 1'b1);
            if (steps[i].kind == ACC_LOOKUP) begin
                check_way("hit_way_o", hit_way, steps[i].exp_way);
                check_word("read_data_o", read_data, steps[i].exp_data);
                if (steps[i].exp_way != '0) begin
                    check_tag("hit_tag_o", hit_tag, steps[i].exp_tag);
                    check_bit("hit_dirty_o", hit_dirty, steps[i].exp_dirty);
                end
            end
        end
        drive_idle();
        @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

    initial begin : watchdog
        longint unsigned limit;
        // Table is built at time zero
        #1;
        limit = (RESET_CYCLES + cache_memctrl_pkg::SETS + steps.size() + MARGIN_CYCLES)
                * CLK_PERIOD;
        #(limit);
        $display("Watchdog expired before the access table was finished");
        abort_run();
    end

endmodule

`default_nettype wire

//--- cache_memctrl.f
+incdir+bench
hdl/cache_memctrl_pkg.sv
hdl/sram_1rw.sv
hdl/dir_access_arb.sv
hdl/dir_array.sv
hdl/data_array.sv
hdl/read_resp.sv
hdl/cache_memctrl_top.sv
bench/cache_memctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the cache controller testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_memctrl_tb \
    -f cache_memctrl.f -Mdir obj_dir || exit 1

./obj_dir/Vcache_memctrl_tb > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0
